// File: src/rp_pkg.sv
// analog path shared types
package rp_pkg;

  ////////////////////////////////////////
  // sample and calibration types
  ////////////////////////////////////////

  // signed sample, converted or calibrated
  typedef logic signed [13:0] sample_t;

  // converter word, two low bits unused
  typedef logic [15:0] raw_adc_t;

  // gain, unity at 2**14
  typedef logic signed [15:0] gain_t;

  // offset added after the shift
  typedef logic signed [13:0] offset_t;

  // free-running cycle count
  typedef logic [63:0] stamp_t;

  ////////////////////////////////////////
  // register port
  ////////////////////////////////////////

  typedef logic [15:0] cfg_data_t;

  // write address map
  typedef enum logic [3:0] {
    ADC_GAIN0 = 4'd0,
    ADC_GAIN1 = 4'd1,
    ADC_OFFS0 = 4'd2,
    ADC_OFFS1 = 4'd3,
    DAC_GAIN0 = 4'd4,
    DAC_GAIN1 = 4'd5,
    DAC_OFFS0 = 4'd6,
    DAC_OFFS1 = 4'd7,
    LOOP_CTRL = 4'd8,   // bit per channel
    DEB_LEN   = 4'd9
  } cfg_addr_e;

  // reset values
  localparam gain_t GAIN_UNITY    = 16'sd16384;
  localparam int    DEB_LEN_RESET = 4;

endpackage : rp_pkg

// File: src/calib_regs.sv
// calibration register set
`timescale 1ns/1ps

module calib_regs #(
  parameter int unsigned DEB_W = 16
) (
  input  logic              adc_clk,
  input  logic              top_rst,
  // write port, single strobe
  input  logic              cfg_we_i,
  input  rp_pkg::cfg_addr_e cfg_addr_i,
  input  rp_pkg::cfg_data_t cfg_wdata_i,
  // gains
  output rp_pkg::gain_t     adc_gain0_o,
  output rp_pkg::gain_t     adc_gain1_o,
  output rp_pkg::gain_t     dac_gain0_o,
  output rp_pkg::gain_t     dac_gain1_o,
  // offsets
  output rp_pkg::offset_t   adc_offs0_o,
  output rp_pkg::offset_t   adc_offs1_o,
  output rp_pkg::offset_t   dac_offs0_o,
  output rp_pkg::offset_t   dac_offs1_o,
  // loopback enables and debounce length
  output logic [1:0]        loop_o,
  output logic [DEB_W-1:0]  deb_len_o
);

  // offsets come from the low bits of the word
  rp_pkg::offset_t wdata_offs;
  assign wdata_offs = rp_pkg::offset_t'(cfg_wdata_i[13:0]);

  ////////////////////////////////////////
  // write decode
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_gain0_o <= rp_pkg::GAIN_UNITY;
      adc_gain1_o <= rp_pkg::GAIN_UNITY;
      dac_gain0_o <= rp_pkg::GAIN_UNITY;
      dac_gain1_o <= rp_pkg::GAIN_UNITY;
      adc_offs0_o <= '0;
      adc_offs1_o <= '0;
      dac_offs0_o <= '0;
      dac_offs1_o <= '0;
      loop_o      <= '0;
      deb_len_o   <= DEB_W'(rp_pkg::DEB_LEN_RESET);
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        rp_pkg::ADC_GAIN0: adc_gain0_o <= rp_pkg::gain_t'(cfg_wdata_i);
        rp_pkg::ADC_GAIN1: adc_gain1_o <= rp_pkg::gain_t'(cfg_wdata_i);
        rp_pkg::ADC_OFFS0: adc_offs0_o <= wdata_offs;
        rp_pkg::ADC_OFFS1: adc_offs1_o <= wdata_offs;
        rp_pkg::DAC_GAIN0: dac_gain0_o <= rp_pkg::gain_t'(cfg_wdata_i);
        rp_pkg::DAC_GAIN1: dac_gain1_o <= rp_pkg::gain_t'(cfg_wdata_i);
        rp_pkg::DAC_OFFS0: dac_offs0_o <= wdata_offs;
        rp_pkg::DAC_OFFS1: dac_offs1_o <= wdata_offs;
        rp_pkg::LOOP_CTRL: loop_o      <= cfg_wdata_i[1:0];
        rp_pkg::DEB_LEN:   deb_len_o   <= DEB_W'(cfg_wdata_i);
        // unmapped addresses dropped
        default: ;
      endcase
    end
  end

  // address has to be driven along with the strobe
  a_addr_known: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    cfg_we_i |-> !$isunknown(cfg_addr_i)
  );

endmodule : calib_regs

// File: src/linear_calib.sv
// linear gain and offset stage
`timescale 1ns/1ps

module linear_calib #(
  parameter int unsigned DWM = 16
) (
  input  logic            adc_clk,
  input  logic            top_rst,
  input  rp_pkg::sample_t dat_i,
  input  rp_pkg::gain_t   gain_i,
  input  rp_pkg::offset_t offs_i,
  output rp_pkg::sample_t dat_o
);

  // sample width and full product width
  localparam int unsigned SW = $bits(rp_pkg::sample_t);
  localparam int unsigned MW = SW + DWM;

  // saturation bounds in sum width
  localparam logic signed [MW:0] SAT_MAX = (MW+1)'(2**(SW-1) - 1);
  localparam logic signed [MW:0] SAT_MIN = (MW+1)'(-(2**(SW-1)));

  logic signed [MW-1:0] mul_r;
  logic signed [MW-1:0] shf;
  logic signed [MW:0]   sum;

  ////////////////////////////////////////
  // stage one, product
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      mul_r <= '0;
    end else begin
      mul_r <= dat_i * gain_i;
    end
  end

  ////////////////////////////////////////
  // stage two, shift, offset, clip
  ////////////////////////////////////////

  // drop the gain fraction, keeps sign
  assign shf = mul_r >>> (DWM - 2);
  // one extra bit so the add cannot wrap
  assign sum = shf + offs_i;

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dat_o <= '0;
    end else if (sum > SAT_MAX) begin
      dat_o <= {1'b0, {(SW-1){1'b1}}};
    end else if (sum < SAT_MIN) begin
      dat_o <= {1'b1, {(SW-1){1'b0}}};
    end else begin
      dat_o <= sum[SW-1:0];
    end
  end

  // sample and register inputs must settle once reset is gone
  a_sum_known: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !$isunknown(sum)
  );

endmodule : linear_calib

// File: src/adc_frontend.sv
// ADC input path
`timescale 1ns/1ps

module adc_frontend #(
  parameter int unsigned DWM = 16
) (
  input  logic             adc_clk,
  input  logic             top_rst,
  // converter words
  input  rp_pkg::raw_adc_t adc_raw0_i,
  input  rp_pkg::raw_adc_t adc_raw1_i,
  // loopback
  input  logic [1:0]       loop_i,
  input  rp_pkg::sample_t  dac_cal0_i,
  input  rp_pkg::sample_t  dac_cal1_i,
  // calibration
  input  rp_pkg::gain_t    gain0_i,
  input  rp_pkg::gain_t    gain1_i,
  input  rp_pkg::offset_t  offs0_i,
  input  rp_pkg::offset_t  offs1_i,
  output rp_pkg::sample_t  adc_dat0_o,
  output rp_pkg::sample_t  adc_dat1_o
);

  rp_pkg::sample_t conv0_r;
  rp_pkg::sample_t conv1_r;
  rp_pkg::sample_t cal_in0;
  rp_pkg::sample_t cal_in1;

  // offset binary to signed, msb kept, rest inverted
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      conv0_r <= '0;
      conv1_r <= '0;
    end else begin
      conv0_r <= {adc_raw0_i[15], ~adc_raw0_i[14:2]};
      conv1_r <= {adc_raw1_i[15], ~adc_raw1_i[14:2]};
    end
  end

  // digital loopback, bypasses the raw register
  assign cal_in0 = loop_i[0] ? dac_cal0_i : conv0_r;
  assign cal_in1 = loop_i[1] ? dac_cal1_i : conv1_r;

  linear_calib #(.DWM(DWM)) u_cal0 (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (cal_in0),
    .gain_i  (gain0_i),
    .offs_i  (offs0_i),
    .dat_o   (adc_dat0_o)
  );

  linear_calib #(.DWM(DWM)) u_cal1 (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (cal_in1),
    .gain_i  (gain1_i),
    .offs_i  (offs1_i),
    .dat_o   (adc_dat1_o)
  );

endmodule : adc_frontend

// File: src/dac_backend.sv
// DAC output path
`timescale 1ns/1ps

module dac_backend #(
  parameter int unsigned DWM = 16
) (
  input  logic            adc_clk,
  input  logic            top_rst,
  // signed samples in
  input  rp_pkg::sample_t dac_in0_i,
  input  rp_pkg::sample_t dac_in1_i,
  // calibration
  input  rp_pkg::gain_t   gain0_i,
  input  rp_pkg::gain_t   gain1_i,
  input  rp_pkg::offset_t offs0_i,
  input  rp_pkg::offset_t offs1_i,
  // calibrated, toward loopback
  output rp_pkg::sample_t dac_cal0_o,
  output rp_pkg::sample_t dac_cal1_o,
  // interleaved converter bus
  output logic [13:0]     dac_dat_o,
  output logic            dac_sel_o
);

  logic [13:0] fmt0;
  logic [13:0] fmt1;

  ////////////////////////////////////////
  // calibration
  ////////////////////////////////////////

  linear_calib #(.DWM(DWM)) u_cal0 (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (dac_in0_i),
    .gain_i  (gain0_i),
    .offs_i  (offs0_i),
    .dat_o   (dac_cal0_o)
  );

  linear_calib #(.DWM(DWM)) u_cal1 (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (dac_in1_i),
    .gain_i  (gain1_i),
    .offs_i  (offs1_i),
    .dat_o   (dac_cal1_o)
  );

  ////////////////////////////////////////
  // format and interleave
  ////////////////////////////////////////

  // signed to converter code, negative slope
  assign fmt0 = {dac_cal0_o[13], ~dac_cal0_o[12:0]};
  assign fmt1 = {dac_cal1_o[13], ~dac_cal1_o[12:0]};

  // select flips each cycle
  // data follows the new select value: high is ch0, low is ch1
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_sel_o <= 1'b0;
      dac_dat_o <= '0;
    end else begin
      dac_sel_o <= ~dac_sel_o;
      dac_dat_o <= dac_sel_o ? fmt1 : fmt0;
    end
  end

  // converter expects strict alternation
  a_sel_toggle: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    $past(!top_rst) |-> (dac_sel_o != $past(dac_sel_o))
  );

endmodule : dac_backend

// File: src/trig_stamp.sv
// trigger debounce and time stamp
`timescale 1ns/1ps

module trig_stamp #(
  parameter int unsigned DEB_W = 16
) (
  input  logic             adc_clk,
  input  logic             top_rst,
  input  logic             trig_i,
  input  logic [DEB_W-1:0] deb_len_i,
  output logic             trig_pos_o,
  output logic             trig_neg_o,
  output rp_pkg::stamp_t   trig_stamp_o
);

  // two flop synchronizer
  logic [1:0]       sync_r;
  logic             trig_s;
  // filtered level and hold counter
  logic             filt_r;
  logic [DEB_W-1:0] hold_r;
  logic             accept;
  // free-running cycle counter
  rp_pkg::stamp_t   cts_r;

  ////////////////////////////////////////
  // synchronizer
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sync_r <= '0;
    end else begin
      sync_r <= {sync_r[0], trig_i};
    end
  end

  assign trig_s = sync_r[1];

  ////////////////////////////////////////
  // debounce
  ////////////////////////////////////////

  // change taken only once the hold time ran out
  assign accept = (hold_r == '0) && (trig_s != filt_r);

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      filt_r     <= 1'b0;
      hold_r     <= '0;
      trig_pos_o <= 1'b0;
      trig_neg_o <= 1'b0;
    end else begin
      trig_pos_o <= accept &  trig_s;
      trig_neg_o <= accept & ~trig_s;
      if (accept) begin
        filt_r <= trig_s;
        hold_r <= deb_len_i;
      end else if (hold_r != '0) begin
        // input ignored while counting down
        hold_r <= hold_r - 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // time stamp
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cts_r        <= '0;
      trig_stamp_o <= '0;
    end else begin
      cts_r <= cts_r + 1'b1;
      // captured together with the strobe, held to next event
      if (accept) begin
        trig_stamp_o <= cts_r;
      end
    end
  end

  // one event per accepted change
  a_one_edge: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !(trig_pos_o && trig_neg_o)
  );

endmodule : trig_stamp

// File: src/rp_analog_top.sv
// analog signal path top
`timescale 1ns/1ps

module rp_analog_top #(
  parameter int unsigned DWM   = 16,
  parameter int unsigned DEB_W = 16
) (
  input  logic              adc_clk,
  input  logic              top_rst,
  // converter and sample streams
  input  rp_pkg::raw_adc_t  adc_raw0_i,
  input  rp_pkg::raw_adc_t  adc_raw1_i,
  input  rp_pkg::sample_t   dac_in0_i,
  input  rp_pkg::sample_t   dac_in1_i,
  input  logic              trig_i,
  // register writes
  input  logic              cfg_we_i,
  input  rp_pkg::cfg_addr_e cfg_addr_i,
  input  rp_pkg::cfg_data_t cfg_wdata_i,
  // outputs
  output rp_pkg::sample_t   adc_dat0_o,
  output rp_pkg::sample_t   adc_dat1_o,
  output logic [13:0]       dac_dat_o,
  output logic              dac_sel_o,
  output logic              trig_pos_o,
  output logic              trig_neg_o,
  output rp_pkg::stamp_t    trig_stamp_o
);

  ////////////////////////////////////////
  // local wires
  ////////////////////////////////////////

  rp_pkg::gain_t    adc_gain0;
  rp_pkg::gain_t    adc_gain1;
  rp_pkg::gain_t    dac_gain0;
  rp_pkg::gain_t    dac_gain1;
  rp_pkg::offset_t  adc_offs0;
  rp_pkg::offset_t  adc_offs1;
  rp_pkg::offset_t  dac_offs0;
  rp_pkg::offset_t  dac_offs1;
  logic [1:0]       loop;
  logic [DEB_W-1:0] deb_len;
  // calibrated DAC samples for loopback
  rp_pkg::sample_t  dac_cal0;
  rp_pkg::sample_t  dac_cal1;

  calib_regs #(.DEB_W(DEB_W)) u_regs (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .adc_gain0_o (adc_gain0),
    .adc_gain1_o (adc_gain1),
    .dac_gain0_o (dac_gain0),
    .dac_gain1_o (dac_gain1),
    .adc_offs0_o (adc_offs0),
    .adc_offs1_o (adc_offs1),
    .dac_offs0_o (dac_offs0),
    .dac_offs1_o (dac_offs1),
    .loop_o      (loop),
    .deb_len_o   (deb_len)
  );

  adc_frontend #(.DWM(DWM)) u_adc (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_raw0_i (adc_raw0_i),
    .adc_raw1_i (adc_raw1_i),
    .loop_i     (loop),
    .dac_cal0_i (dac_cal0),
    .dac_cal1_i (dac_cal1),
    .gain0_i    (adc_gain0),
    .gain1_i    (adc_gain1),
    .offs0_i    (adc_offs0),
    .offs1_i    (adc_offs1),
    .adc_dat0_o (adc_dat0_o),
    .adc_dat1_o (adc_dat1_o)
  );

  dac_backend #(.DWM(DWM)) u_dac (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .dac_in0_i  (dac_in0_i),
    .dac_in1_i  (dac_in1_i),
    .gain0_i    (dac_gain0),
    .gain1_i    (dac_gain1),
    .offs0_i    (dac_offs0),
    .offs1_i    (dac_offs1),
    .dac_cal0_o (dac_cal0),
    .dac_cal1_o (dac_cal1),
    .dac_dat_o  (dac_dat_o),
    .dac_sel_o  (dac_sel_o)
  );

  trig_stamp #(.DEB_W(DEB_W)) u_trig (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .trig_i       (trig_i),
    .deb_len_i    (deb_len),
    .trig_pos_o   (trig_pos_o),
    .trig_neg_o   (trig_neg_o),
    .trig_stamp_o (trig_stamp_o)
  );

endmodule : rp_analog_top

// File: tests/tb_rp_analog_top.sv
// analog path testbench
`timescale 1ns/1ps

module tb_rp_analog_top;

  localparam int unsigned DWM   = 16;
  localparam int unsigned DEB_W = 16;
  // cycles allowed for a trigger event to show up
  localparam int          STROBE_TIMEOUT = 200;
  localparam logic [31:0] SEED = 32'h921f_e195;

  logic              adc_clk;
  logic              top_rst;
  rp_pkg::raw_adc_t  adc_raw0_i;
  rp_pkg::raw_adc_t  adc_raw1_i;
  rp_pkg::sample_t   dac_in0_i;
  rp_pkg::sample_t   dac_in1_i;
  logic              trig_i;
  logic              cfg_we_i;
  rp_pkg::cfg_addr_e cfg_addr_i;
  rp_pkg::cfg_data_t cfg_wdata_i;
  rp_pkg::sample_t   adc_dat0_o;
  rp_pkg::sample_t   adc_dat1_o;
  logic [13:0]       dac_dat_o;
  logic              dac_sel_o;
  logic              trig_pos_o;
  logic              trig_neg_o;
  rp_pkg::stamp_t    trig_stamp_o;

  // register shadows kept in step with every write
  logic signed [15:0] adc_gain_m [2];
  logic signed [13:0] adc_offs_m [2];
  logic signed [15:0] dac_gain_m [2];
  logic signed [13:0] dac_offs_m [2];
  logic [1:0]         loop_m;
  logic [31:0]        rng;

  rp_analog_top #(.DWM(DWM), .DEB_W(DEB_W)) u_dut (.*);

  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // offset binary with the two low bits dropped
  function automatic logic signed [13:0] adc_conv(input logic [15:0] raw);
    return {raw[15], ~raw[14:2]};
  endfunction

  // multiply, shift by 14, add, clip to 14 bits signed
  function automatic logic signed [13:0] calib_model(input logic signed [13:0] x,
                                                     input logic signed [15:0] g,
                                                     input logic signed [13:0] o);
    longint p;
    longint s;
    p = longint'(x) * longint'(g);
    s = (p >>> 14) + longint'(o);
    if (s > 8191) begin
      return 14'sh1fff;
    end else if (s < -8192) begin
      return 14'sh2000;
    end
    return s[13:0];
  endfunction

  // converter code keeps the msb and inverts the rest
  function automatic logic [13:0] dac_format(input logic signed [13:0] s);
    return {s[13], ~s[12:0]};
  endfunction

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic check_eq(input string name, input logic [63:0] exp_v,
                          input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      $display("Error: %s expected %0h actual %0h", name, exp_v, act_v);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic wait_cycles(input int n);
    int k;
    for (k = 0; k < n; k++) begin
      @(negedge adc_clk);
    end
  endtask

  // one strobe on the write port
  task automatic cfg_write(input rp_pkg::cfg_addr_e addr, input logic [15:0] data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    wait_cycles(1);
    cfg_we_i    = 1'b0;
  endtask

  task automatic set_channel_cal(input bit is_dac, input int ch, input logic [15:0] g,
                                 input logic [15:0] o);
    rp_pkg::cfg_addr_e ga;
    rp_pkg::cfg_addr_e oa;
    if (is_dac) begin
      ga = (ch == 0) ? rp_pkg::DAC_GAIN0 : rp_pkg::DAC_GAIN1;
      oa = (ch == 0) ? rp_pkg::DAC_OFFS0 : rp_pkg::DAC_OFFS1;
      dac_gain_m[ch] = g;
      dac_offs_m[ch] = o[13:0];
    end else begin
      ga = (ch == 0) ? rp_pkg::ADC_GAIN0 : rp_pkg::ADC_GAIN1;
      oa = (ch == 0) ? rp_pkg::ADC_OFFS0 : rp_pkg::ADC_OFFS1;
      adc_gain_m[ch] = g;
      adc_offs_m[ch] = o[13:0];
    end
    cfg_write(ga, g);
    cfg_write(oa, o);
  endtask

  task automatic set_loop(input logic [1:0] en);
    loop_m = en;
    cfg_write(rp_pkg::LOOP_CTRL, {14'd0, en});
  endtask

  // loopback takes the calibrated DAC sample instead of the raw word
  task automatic check_adc_outputs(input string name);
    logic signed [13:0] in0;
    logic signed [13:0] in1;
    in0 = loop_m[0] ? calib_model(dac_in0_i, dac_gain_m[0], dac_offs_m[0])
                    : adc_conv(adc_raw0_i);
    in1 = loop_m[1] ? calib_model(dac_in1_i, dac_gain_m[1], dac_offs_m[1])
                    : adc_conv(adc_raw1_i);
    check_eq(name, 64'(calib_model(in0, adc_gain_m[0], adc_offs_m[0])), 64'(adc_dat0_o));
    check_eq(name, 64'(calib_model(in1, adc_gain_m[1], adc_offs_m[1])), 64'(adc_dat1_o));
  endtask

  task automatic wait_strobe(input bit want_pos, output logic [63:0] stamp);
    int  n;
    bit  found;
    n     = 0;
    found = 1'b0;
    while (!found && n < STROBE_TIMEOUT) begin
      wait_cycles(1);
      n++;
      if (want_pos ? trig_pos_o : trig_neg_o) begin
        found = 1'b1;
        stamp = trig_stamp_o;
      end
    end
    if (!found) begin
      $display("no trigger strobe arrived within %0d cycles", STROBE_TIMEOUT);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic adc_reset_path();
    int k;
    for (k = 0; k < 4; k++) begin
      rng = xorshift(rng);
      adc_raw0_i = rng[15:0];
      adc_raw1_i = rng[31:16];
      wait_cycles(8);
      check_adc_outputs("adc_reset_path");
    end
  endtask

  task automatic adc_calibration();
    int k;
    for (k = 0; k < 6; k++) begin
      if (k == 0) begin
        // both channels pushed into the rails
        set_channel_cal(1'b0, 0, 16'h7fff, 16'h1fff);
        set_channel_cal(1'b0, 1, 16'h7fff, 16'h2000);
        adc_raw0_i = 16'h0000;
        adc_raw1_i = 16'hfffc;
      end else begin
        rng = xorshift(rng);
        set_channel_cal(1'b0, 0, rng[15:0], rng[31:16]);
        rng = xorshift(rng);
        set_channel_cal(1'b0, 1, rng[15:0], rng[31:16]);
        rng = xorshift(rng);
        adc_raw0_i = rng[15:0];
        adc_raw1_i = rng[31:16];
      end
      wait_cycles(8);
      check_adc_outputs("adc_calibration");
    end
  endtask

  task automatic dac_interleave();
    int          k;
    logic        prev_sel;
    logic [13:0] exp_v;
    rng = xorshift(rng);
    set_channel_cal(1'b1, 0, {2'b00, rng[13:0]}, rng[31:16]);
    rng = xorshift(rng);
    set_channel_cal(1'b1, 1, {2'b00, rng[13:0]}, rng[31:16]);
    rng = xorshift(rng);
    dac_in0_i = rng[13:0];
    dac_in1_i = rng[29:16];
    wait_cycles(8);
    prev_sel = dac_sel_o;
    for (k = 0; k < 6; k++) begin
      wait_cycles(1);
      check_eq("dac_interleave select", 64'(!prev_sel), 64'(dac_sel_o));
      if (dac_sel_o) begin
        exp_v = dac_format(calib_model(dac_in0_i, dac_gain_m[0], dac_offs_m[0]));
      end else begin
        exp_v = dac_format(calib_model(dac_in1_i, dac_gain_m[1], dac_offs_m[1]));
      end
      check_eq("dac_interleave data", 64'(exp_v), 64'(dac_dat_o));
      prev_sel = dac_sel_o;
    end
  endtask

  task automatic loopback_path();
    rng = xorshift(rng);
    set_channel_cal(1'b0, 0, {2'b00, rng[13:0]}, rng[31:16]);
    rng = xorshift(rng);
    set_channel_cal(1'b0, 1, {2'b00, rng[13:0]}, rng[31:16]);
    set_loop(2'b11);
    rng = xorshift(rng);
    dac_in0_i  = rng[13:0];
    dac_in1_i  = rng[29:16];
    // raw words change too and must not leak through
    adc_raw0_i = ~rng[15:0];
    adc_raw1_i = ~rng[31:16];
    wait_cycles(8);
    check_adc_outputs("loopback_path on");
    set_loop(2'b00);
    wait_cycles(8);
    check_adc_outputs("loopback_path off");
  endtask

  task automatic trigger_stamps();
    int          k;
    int          pos_cnt;
    int          neg_cnt;
    logic [63:0] pos_stamp;
    logic [63:0] neg_stamp;
    pos_cnt   = 0;
    neg_cnt   = 0;
    pos_stamp = '0;
    cfg_write(rp_pkg::DEB_LEN, 16'd4);
    wait_cycles(2);
    // rise, then fall exactly 20 cycles later
    trig_i = 1'b1;
    for (k = 0; k < 20; k++) begin
      wait_cycles(1);
      if (trig_pos_o) begin
        pos_cnt++;
        pos_stamp = trig_stamp_o;
      end
      if (trig_neg_o) begin
        neg_cnt++;
      end
    end
    trig_i = 1'b0;
    wait_strobe(1'b0, neg_stamp);
    check_eq("trigger_stamps pos count", 64'd1, 64'(pos_cnt));
    check_eq("trigger_stamps early neg", 64'd0, 64'(neg_cnt));
    check_eq("trigger_stamps delta", 64'd20, neg_stamp - pos_stamp);
  endtask

  task automatic glitch_filter();
    int k;
    int pos_cnt;
    int neg_cnt;
    int pos_at;
    int neg_at;
    pos_cnt = 0;
    neg_cnt = 0;
    pos_at  = -1;
    neg_at  = -1;
    cfg_write(rp_pkg::DEB_LEN, 16'd30);
    wait_cycles(2);
    // four toggles in six cycles, ending low, then a 60 cycle watch
    for (k = 0; k < 66; k++) begin
      trig_i = (k == 0) || (k == 3) || (k == 4);
      wait_cycles(1);
      if (trig_pos_o) begin
        pos_cnt++;
        pos_at = k;
      end
      if (trig_neg_o) begin
        neg_cnt++;
        neg_at = k;
      end
    end
    check_eq("glitch_filter pos count", 64'd1, 64'(pos_cnt));
    check_eq("glitch_filter neg count", 64'd1, 64'(neg_cnt));
    check_eq("glitch_filter order", 64'd1, 64'(neg_at > pos_at));
  endtask

  ////////////////////////////////////////
  // sequence
  ////////////////////////////////////////

  initial begin
    top_rst     = 1'b1;
    adc_raw0_i  = '0;
    adc_raw1_i  = '0;
    dac_in0_i   = '0;
    dac_in1_i   = '0;
    trig_i      = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = rp_pkg::ADC_GAIN0;
    cfg_wdata_i = '0;
    adc_gain_m  = '{16'sd16384, 16'sd16384};
    dac_gain_m  = '{16'sd16384, 16'sd16384};
    adc_offs_m  = '{14'sd0, 14'sd0};
    dac_offs_m  = '{14'sd0, 14'sd0};
    loop_m      = 2'b00;
    rng         = SEED;
    wait_cycles(10);
    // outputs still cleared while reset holds
    check_eq("reset adc_dat0_o", 64'd0, 64'(adc_dat0_o));
    check_eq("reset adc_dat1_o", 64'd0, 64'(adc_dat1_o));
    check_eq("reset dac_dat_o", 64'd0, 64'(dac_dat_o));
    check_eq("reset dac_sel_o", 64'd0, 64'(dac_sel_o));
    check_eq("reset trig strobes", 64'd0, 64'({trig_pos_o, trig_neg_o}));
    check_eq("reset trig_stamp_o", 64'd0, trig_stamp_o);
    top_rst = 1'b0;
    wait_cycles(2);
    adc_reset_path();
    adc_calibration();
    dac_interleave();
    loopback_path();
    trigger_stamps();
    glitch_filter();
    $display("TEST PASSED");
    $finish;
  end

endmodule : tb_rp_analog_top

// File: rp_analog_top.f
src/rp_pkg.sv
src/calib_regs.sv
src/linear_calib.sv
src/adc_frontend.sv
src/dac_backend.sv
src/trig_stamp.sv
src/rp_analog_top.sv
tests/tb_rp_analog_top.sv

// File: Makefile
# Verilator build for the analog path testbench

TOP             ?= tb_rp_analog_top
SRC_LIST        ?= rp_analog_top.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert
OBJ_DIR         ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(SRC_LIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
